//--- Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decodeTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASSTEXT  ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Status comes from the pass line in the output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASSTEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- project.f
+incdir+include
source/isaPkg.sv
source/ctrlPkg.sv
source/instrDecoder.sv
source/regFile.sv
source/decodeStage.sv
tests/clockGen.sv
tests/decodeChecker.sv
tests/decodeTb.sv

//--- source/ctrlPkg.sv
package ctrlPkg;

    import isaPkg::*;

    typedef enum logic [3:0] {
        aluAdd = 4'b0000,
        aluSub = 4'b0001,
        aluAnd = 4'b0010,
        aluOr  = 4'b0011,
        aluNeg = 4'b0100,
        aluNot = 4'b0101,
        aluSll = 4'b0110,
        aluSra = 4'b1000,
        aluSlt = 4'b1001,
        aluCmp = 4'b1010,
        aluPc  = 4'b1011
    } aluOpE;

    // Second ALU operand
    typedef enum logic [1:0] {
        srcBReg  = 2'b00,
        srcBImm  = 2'b01,
        srcBNone = 2'b10
    } srcBE;

    typedef enum logic [1:0] {
        memRead  = 2'b01,
        memWrite = 2'b10,
        memNone  = 2'b11
    } memOpE;

    typedef enum logic [2:0] {
        brNone,
        brAlways,
        brReg,
        brEqz,
        brNez
    } branchE;

    typedef struct packed {
        aluOpE               aluOp;
        srcBE                srcB;
        memOpE               memOp;
        branchE              branch;
        regIdxT              writeReg;
        logic [ImmWidth-1:0] imm;
    } ctrlT;

    // Default data width of the write-back path
    typedef struct packed {
        regIdxT      regIdx;
        logic [15:0] data;
    } writeBackT;

    localparam ctrlT ctrlNop = '{aluAdd, srcBNone, memNone, brNone, regNone, '0};

endpackage

//--- source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage
    import isaPkg::*;
    import ctrlPkg::*;
#(
    parameter int DataWidth = 16
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  instrT                                instr,
    input  logic                                 instrValid,
    input  logic [$bits(regIdxT)+DataWidth-1:0] writeBack,
    output logic                                 outValid,
    output ctrlT                                 ctrl,
    output regIdxT                               readReg1,
    output regIdxT                               readReg2,
    output logic [DataWidth-1:0]                 readData1,
    output logic [DataWidth-1:0]                 readData2
);

    // One decoded instruction as handed to execute
    typedef struct packed {
        ctrlT                 ctrl;
        regIdxT               readReg1;
        regIdxT               readReg2;
        logic [DataWidth-1:0] readData1;
        logic [DataWidth-1:0] readData2;
    } stageT;

    ctrlT                 decCtrl;
    regIdxT               decReg1;
    regIdxT               decReg2;
    logic [DataWidth-1:0] rfData1;
    logic [DataWidth-1:0] rfData2;
    stageT                stageQ;

    instrDecoder i_instrDecoder (
        .instr    (instr),
        .readReg1 (decReg1),
        .readReg2 (decReg2),
        .ctrl     (decCtrl)
    );

    regFile #(
        .DataWidth (DataWidth)
    ) i_regFile (
        .clk       (clk),
        .rst       (rst),
        .readReg1  (decReg1),
        .readReg2  (decReg2),
        .writeBack (writeBack),
        .readData1 (rfData1),
        .readData2 (rfData2)
    );

    ////////////////////////////////////////////////////////////
    // Output pipeline register

    always_ff @(posedge clk) begin
        if (!rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            stageQ <= '{decCtrl, decReg1, decReg2, rfData1, rfData2};  // Held as is when idle
        end
    end

    assign ctrl      = stageQ.ctrl;
    assign readReg1  = stageQ.readReg1;
    assign readReg2  = stageQ.readReg2;
    assign readData1 = stageQ.readData1;
    assign readData2 = stageQ.readData2;

    assert property (@(posedge clk) !rst |=> !outValid);

endmodule

//--- source/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  instrT  instr,
    output regIdxT readReg1,
    output regIdxT readReg2,
    output ctrlT   ctrl
);

    opcodeE op;
    regIdxT rx;
    regIdxT ry;
    regIdxT rz;
    logic [ImmWidth-1:0] sx11;
    logic [ImmWidth-1:0] sx8;
    logic [ImmWidth-1:0] sx5;
    logic [ImmWidth-1:0] sx4;
    logic [ImmWidth-1:0] zx8;
    logic [ImmWidth-1:0] shamt;

    ////////////////////////////////////////////////////////////
    // Fields and immediates

    assign op = opcodeE'(instr[15:11]);
    assign rx = {1'b0, instr[10:8]};
    assign ry = {1'b0, instr[7:5]};
    assign rz = {1'b0, instr[4:2]};

    assign sx11  = {{5{instr[10]}}, instr[10:0]};
    assign sx8   = {{8{instr[7]}}, instr[7:0]};
    assign sx5   = {{11{instr[4]}}, instr[4:0]};
    assign sx4   = {{12{instr[3]}}, instr[3:0]};
    assign zx8   = {8'b0, instr[7:0]};
    assign shamt = (instr[4:2] == 3'b000) ? 16'd8 : {13'b0, instr[4:2]};  // 0 shifts by 8

    ////////////////////////////////////////////////////////////
    // Decode table

    always_comb begin
        readReg1 = regNone;
        readReg2 = regNone;
        ctrl     = ctrlNop;
        case (op)
            opB: begin
                ctrl.branch = brAlways;
                ctrl.imm    = sx11;
            end
            opBeqz, opBnez: begin
                readReg1    = rx;
                ctrl.aluOp  = aluSub;
                ctrl.branch = (op == opBeqz) ? brEqz : brNez;
                ctrl.imm    = sx8;
            end
            opShift: begin
                if (instr[1:0] == 2'b00 || instr[1:0] == 2'b11) begin
                    readReg1      = ry;
                    ctrl.aluOp    = instr[0] ? aluSra : aluSll;
                    ctrl.srcB     = srcBImm;
                    ctrl.writeReg = rx;
                    ctrl.imm      = shamt;
                end
            end
            opAddiu3: begin
                readReg1      = rx;
                ctrl.srcB     = srcBImm;
                ctrl.writeReg = ry;
                ctrl.imm      = sx4;
            end
            opAddiu, opSltui: begin
                readReg1      = rx;
                ctrl.srcB     = srcBImm;
                ctrl.aluOp    = (op == opSltui) ? aluSlt : aluAdd;
                ctrl.writeReg = (op == opSltui) ? regT : rx;
                ctrl.imm      = (op == opSltui) ? zx8 : sx8;
            end
            opSpGroup: begin
                case (instr[10:8])
                    3'b011: begin  // ADDSP
                        readReg1      = regSp;
                        ctrl.srcB     = srcBImm;
                        ctrl.writeReg = regSp;
                        ctrl.imm      = sx8;
                    end
                    3'b000: begin  // BTEQZ
                        readReg1    = regT;
                        ctrl.aluOp  = aluSub;
                        ctrl.branch = brEqz;
                        ctrl.imm    = sx8;
                    end
                    3'b100: begin  // MTSP
                        readReg1      = ry;
                        ctrl.writeReg = regSp;
                    end
                    default: ;
                endcase
            end
            opLi: begin
                ctrl.srcB     = srcBImm;
                ctrl.writeReg = rx;
                ctrl.imm      = zx8;
            end
            opMove: begin
                readReg1      = ry;
                ctrl.srcB     = srcBReg;
                ctrl.writeReg = rx;
            end
            opLwSp, opLw: begin
                readReg1      = (op == opLwSp) ? regSp : rx;
                ctrl.srcB     = srcBImm;
                ctrl.memOp    = memRead;
                ctrl.writeReg = (op == opLwSp) ? rx : ry;
                ctrl.imm      = (op == opLwSp) ? sx8 : sx5;
            end
            opSwSp: begin
                readReg1   = regSp;
                readReg2   = rx;
                ctrl.memOp = memWrite;
                ctrl.imm   = sx8;
            end
            opSw: begin
                readReg1   = rx;
                readReg2   = ry;
                ctrl.srcB  = srcBImm;
                ctrl.memOp = memWrite;
                ctrl.imm   = sx5;
            end
            opAddSub: begin
                if (instr[0]) begin  // ADDU 01, SUBU 11
                    readReg1      = rx;
                    readReg2      = ry;
                    ctrl.aluOp    = instr[1] ? aluSub : aluAdd;
                    ctrl.srcB     = srcBReg;
                    ctrl.writeReg = rz;
                end
            end
            opAlu: begin
                case (instr[4:0])
                    5'b00000: begin
                        if (instr[7:5] == 3'b000) begin  // JR
                            readReg1    = rx;
                            ctrl.branch = brReg;
                        end else if (instr[7:5] == 3'b010) begin  // MFPC
                            ctrl.aluOp    = aluPc;
                            ctrl.writeReg = rx;
                        end
                    end
                    5'b00010, 5'b01010, 5'b01100, 5'b01101: begin
                        readReg1      = rx;
                        readReg2      = ry;
                        ctrl.srcB     = srcBReg;
                        ctrl.writeReg = instr[3] ? rx : regT;  // SLT and CMP set T
                        case (instr[3:0])
                            4'b0010: ctrl.aluOp = aluSlt;
                            4'b1010: ctrl.aluOp = aluCmp;
                            4'b1100: ctrl.aluOp = aluAnd;
                            default: ctrl.aluOp = aluOr;
                        endcase
                        if (instr[3:0] == 4'b1010) begin
                            ctrl.writeReg = regT;
                        end
                    end
                    5'b01011, 5'b01111: begin  // NEG, NOT
                        readReg1      = ry;
                        ctrl.aluOp    = instr[2] ? aluNot : aluNeg;
                        ctrl.srcB     = instr[2] ? srcBNone : srcBReg;
                        ctrl.writeReg = rx;
                    end
                    default: ;
                endcase
            end
            opIhGroup: begin
                if (instr[7:1] == 7'b0) begin
                    readReg1      = instr[0] ? rx : regIh;  // MTIH : MFIH
                    ctrl.writeReg = instr[0] ? regIh : rx;
                end
            end
            default: ;  // NOP and unassigned opcodes
        endcase
    end

    // A branch never touches memory
    always_comb begin
        assert (ctrl.branch == brNone || ctrl.memOp == memNone);
    end

endmodule

//--- source/isaPkg.sv
package isaPkg;

    typedef logic [15:0] instrT;
    typedef logic [3:0]  regIdxT;

    // Width of the extended immediate
    localparam int ImmWidth = 16;

    // Major opcode, instr[15:11]
    typedef enum logic [4:0] {
        opNop     = 5'b00001,
        opB       = 5'b00010,
        opBeqz    = 5'b00100,
        opBnez    = 5'b00101,
        opShift   = 5'b00110,   // SLL / SRA on instr[1:0]
        opAddiu3  = 5'b01000,
        opAddiu   = 5'b01001,
        opSltui   = 5'b01011,
        opSpGroup = 5'b01100,   // ADDSP, BTEQZ, MTSP on instr[10:8]
        opLi      = 5'b01101,
        opMove    = 5'b01111,
        opLwSp    = 5'b10010,
        opLw      = 5'b10011,
        opSwSp    = 5'b11010,
        opSw      = 5'b11011,
        opAddSub  = 5'b11100,
        opAlu     = 5'b11101,   // Register ALU ops and JR / MFPC
        opIhGroup = 5'b11110
    } opcodeE;

    ////////////////////////////////////////////////////////////
    // Special registers

    localparam regIdxT regSp   = 4'd8;
    localparam regIdxT regT    = 4'd9;
    localparam regIdxT regIh   = 4'd10;
    localparam regIdxT regNone = 4'd15;  // Reads as zero, writes dropped

endpackage

//--- source/regFile.sv
`timescale 1ns/1ps

module regFile
    import isaPkg::*;
#(
    parameter int DataWidth = 16
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  regIdxT                               readReg1,
    input  regIdxT                               readReg2,
    input  logic [$bits(regIdxT)+DataWidth-1:0] writeBack,
    output logic [DataWidth-1:0]                 readData1,
    output logic [DataWidth-1:0]                 readData2
);

    typedef struct packed {
        regIdxT               regIdx;
        logic [DataWidth-1:0] data;
    } wbT;

    wbT wb;
    logic [DataWidth-1:0] regs [16];

    assign wb = writeBack;

    ////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.regIdx != regNone) begin
            regs[wb.regIdx] <= wb.data;
        end
    end

    // Zero register, then same-cycle write-back, then storage
    function automatic logic [DataWidth-1:0] readPort(input regIdxT idx);
        if (idx == regNone) begin
            return '0;
        end else if (idx == wb.regIdx) begin
            return wb.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        readData1 = readPort(readReg1);
        readData2 = readPort(readReg2);
    end

    assert property (@(posedge clk) disable iff (!rst) readReg1 == regNone |-> readData1 == '0);
    assert property (@(posedge clk) disable iff (!rst) readReg2 == regNone |-> readData2 == '0);

endmodule

//--- tests/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int HalfPeriod  = 5,
    parameter int ResetCycles = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HalfPeriod) clk = ~clk;  // 10 ns period
    end

    initial begin
        rst = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

//--- include/decodeRef.svh
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

typedef logic [15:0] refRegsT [16];

// Expected read indices and bundle
typedef struct packed {
    regIdxT r1;
    regIdxT r2;
    ctrlT   c;
} refOutT;

// Pattern match on the whole word
function automatic refOutT refDecode(input instrT i);
    regIdxT x;
    regIdxT y;
    regIdxT z;
    logic [15:0] s8;
    logic [15:0] s5;
    logic [15:0] u8;
    logic [15:0] sh;
    refOutT e;
    x  = {1'b0, i[10:8]};
    y  = {1'b0, i[7:5]};
    z  = {1'b0, i[4:2]};
    s8 = 16'(signed'(i[7:0]));
    s5 = 16'(signed'(i[4:0]));
    u8 = 16'(i[7:0]);
    sh = (i[4:2] == 3'd0) ? 16'd8 : 16'(i[4:2]);
    casez (i)
        16'b00010_???????????:
            e = '{regNone, regNone, '{aluAdd, srcBNone, memNone, brAlways, regNone,
                  16'(signed'(i[10:0]))}};
        16'b00100_???????????: e = '{x, regNone, '{aluSub, srcBNone, memNone, brEqz, regNone, s8}};
        16'b00101_???????????: e = '{x, regNone, '{aluSub, srcBNone, memNone, brNez, regNone, s8}};
        16'b00110_?????????_00: e = '{y, regNone, '{aluSll, srcBImm, memNone, brNone, x, sh}};
        16'b00110_?????????_11: e = '{y, regNone, '{aluSra, srcBImm, memNone, brNone, x, sh}};
        16'b01000_???????????:
            e = '{x, regNone, '{aluAdd, srcBImm, memNone, brNone, y, 16'(signed'(i[3:0]))}};
        16'b01001_???????????: e = '{x, regNone, '{aluAdd, srcBImm, memNone, brNone, x, s8}};
        16'b01011_???????????: e = '{x, regNone, '{aluSlt, srcBImm, memNone, brNone, regT, u8}};
        16'b01100_011_????????:
            e = '{regSp, regNone, '{aluAdd, srcBImm, memNone, brNone, regSp, s8}};
        16'b01100_000_????????:
            e = '{regT, regNone, '{aluSub, srcBNone, memNone, brEqz, regNone, s8}};
        16'b01100_100_????????:
            e = '{y, regNone, '{aluAdd, srcBNone, memNone, brNone, regSp, '0}};
        16'b01101_???????????:
            e = '{regNone, regNone, '{aluAdd, srcBImm, memNone, brNone, x, u8}};
        16'b01111_???????????: e = '{y, regNone, '{aluAdd, srcBReg, memNone, brNone, x, '0}};
        16'b10010_???????????: e = '{regSp, regNone, '{aluAdd, srcBImm, memRead, brNone, x, s8}};
        16'b10011_???????????: e = '{x, regNone, '{aluAdd, srcBImm, memRead, brNone, y, s5}};
        16'b11010_???????????:
            e = '{regSp, x, '{aluAdd, srcBNone, memWrite, brNone, regNone, s8}};
        16'b11011_???????????: e = '{x, y, '{aluAdd, srcBImm, memWrite, brNone, regNone, s5}};
        16'b11100_?????????_01: e = '{x, y, '{aluAdd, srcBReg, memNone, brNone, z, '0}};
        16'b11100_?????????_11: e = '{x, y, '{aluSub, srcBReg, memNone, brNone, z, '0}};
        16'b11101_???_000_00000:
            e = '{x, regNone, '{aluAdd, srcBNone, memNone, brReg, regNone, '0}};
        16'b11101_???_010_00000:
            e = '{regNone, regNone, '{aluPc, srcBNone, memNone, brNone, x, '0}};
        16'b11101_??????_00010: e = '{x, y, '{aluSlt, srcBReg, memNone, brNone, regT, '0}};
        16'b11101_??????_01010: e = '{x, y, '{aluCmp, srcBReg, memNone, brNone, regT, '0}};
        16'b11101_??????_01011: e = '{y, regNone, '{aluNeg, srcBReg, memNone, brNone, x, '0}};
        16'b11101_??????_01100: e = '{x, y, '{aluAnd, srcBReg, memNone, brNone, x, '0}};
        16'b11101_??????_01101: e = '{x, y, '{aluOr, srcBReg, memNone, brNone, x, '0}};
        16'b11101_??????_01111: e = '{y, regNone, '{aluNot, srcBNone, memNone, brNone, x, '0}};
        16'b11110_???_00000000:
            e = '{regIh, regNone, '{aluAdd, srcBNone, memNone, brNone, x, '0}};
        16'b11110_???_00000001:
            e = '{x, regNone, '{aluAdd, srcBNone, memNone, brNone, regIh, '0}};
        default: e = '{regNone, regNone, ctrlNop};
    endcase
    return e;
endfunction

// Read with zero register and same-cycle forwarding
function automatic logic [15:0] refRead(input refRegsT regs, input regIdxT idx,
                                        input writeBackT wb);
    if (idx == regNone) begin
        return '0;
    end
    return (idx == wb.regIdx) ? wb.data : regs[idx];
endfunction

function automatic void refWrite(inout refRegsT regs, input writeBackT wb);
    if (wb.regIdx != regNone) begin
        regs[wb.regIdx] = wb.data;
    end
endfunction

`endif

//--- tests/decodeChecker.sv
`timescale 1ns/1ps

module decodeChecker
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  instrT       instr,
    input  logic        instrValid,
    input  writeBackT   writeBack,
    input  logic        outValid,
    input  ctrlT        ctrl,
    input  regIdxT      readReg1,
    input  regIdxT      readReg2,
    input  logic [15:0] readData1,
    input  logic [15:0] readData2,
    output int          errorCount,
    output int          checkCount
);

    `include "decodeRef.svh"

    refRegsT     model;
    refOutT      expOut;
    logic [15:0] expData1;
    logic [15:0] expData2;
    logic        expValid;
    logic        primed;

    initial begin
        errorCount = 0;
        checkCount = 0;
        primed     = 1'b0;
        expValid   = 1'b0;
    end

    task automatic compareField(input string name, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
        if (gotVal !== expVal) begin
            errorCount++;
            $display("Error %0t: %s expected %0h got %0h", $time, name, expVal, gotVal);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Expected values at each edge

    always @(posedge clk) begin
        primed = 1'b1;
        if (!rst) begin
            expValid = 1'b0;
            for (int r = 0; r < 16; r++) begin
                model[r] = '0;
            end
        end else begin
            expOut   = refDecode(instr);
            expData1 = refRead(model, expOut.r1, writeBack);  // Before this edge's write
            expData2 = refRead(model, expOut.r2, writeBack);
            refWrite(model, writeBack);
            expValid = instrValid;
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare half a cycle later

    always @(negedge clk) begin
        if (primed) begin
            compareField("outValid", 32'(expValid), 32'(outValid));
            if (expValid) begin
                checkCount++;
                compareField("aluOp", 32'(expOut.c.aluOp), 32'(ctrl.aluOp));
                compareField("srcB", 32'(expOut.c.srcB), 32'(ctrl.srcB));
                compareField("memOp", 32'(expOut.c.memOp), 32'(ctrl.memOp));
                compareField("branch", 32'(expOut.c.branch), 32'(ctrl.branch));
                compareField("writeReg", 32'(expOut.c.writeReg), 32'(ctrl.writeReg));
                compareField("imm", 32'(expOut.c.imm), 32'(ctrl.imm));
                compareField("readReg1", 32'(expOut.r1), 32'(readReg1));
                compareField("readReg2", 32'(expOut.r2), 32'(readReg2));
                compareField("readData1", 32'(expData1), 32'(readData1));
                compareField("readData2", 32'(expData2), 32'(readData2));
            end
        end
    end

endmodule

//--- tests/decodeTb.sv
`timescale 1ns/1ps

module decodeTb
    import isaPkg::*;
    import ctrlPkg::*;
;

    localparam int DataWidth = 16;
    localparam writeBackT noWrite = '{regNone, 16'h0000};

    logic        clk;
    logic        rst;
    instrT       instr;
    logic        instrValid;
    writeBackT   writeBack;
    logic        outValid;
    ctrlT        ctrl;
    regIdxT      readReg1;
    regIdxT      readReg2;
    logic [15:0] readData1;
    logic [15:0] readData2;
    int          errorCount;
    int          checkCount;

    int          seed;
    int          issuedCount;
    int          timeouts;
    int          waited;
    logic [31:0] rnd;
    logic [31:0] gap;
    writeBackT   wbRand;
    instrT       dirList[$];

    clockGen i_clockGen (
        .clk (clk),
        .rst (rst)
    );

    decodeStage #(
        .DataWidth (DataWidth)
    ) i_decodeStage (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .instrValid (instrValid),
        .writeBack  (writeBack),
        .outValid   (outValid),
        .ctrl       (ctrl),
        .readReg1   (readReg1),
        .readReg2   (readReg2),
        .readData1  (readData1),
        .readData2  (readData2)
    );

    decodeChecker i_decodeChecker (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .instrValid (instrValid),
        .writeBack  (writeBack),
        .outValid   (outValid),
        .ctrl       (ctrl),
        .readReg1   (readReg1),
        .readReg2   (readReg2),
        .readData1  (readData1),
        .readData2  (readData2),
        .errorCount (errorCount),
        .checkCount (checkCount)
    );

    function automatic writeBackT packWriteBack(input regIdxT idx, input logic [15:0] data);
        writeBackT wb;
        wb.regIdx = idx;
        wb.data   = data;
        return wb;
    endfunction

    // Drive one cycle's inputs just after the edge
    task automatic issue(input instrT word, input logic valid, input writeBackT wbIn);
        @(posedge clk);
        #1;
        instr      = word;
        instrValid = valid;
        writeBack  = wbIn;
        if (valid) begin
            issuedCount++;
        end
    endtask

    initial begin
        instr       = 16'h0800;
        instrValid  = 1'b0;
        writeBack   = noWrite;
        seed        = 32'h118;
        issuedCount = 0;
        timeouts    = 0;

        waited = 0;
        while (rst !== 1'b1 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (rst !== 1'b1) begin
            $display("Timed out waiting for reset to be released");
            timeouts++;
        end

        ////////////////////////////////////////////////////////////
        // Registers read as zero after reset

        for (int r = 0; r < 8; r++) begin
            issue(16'hD800 | instrT'(r << 8) | instrT'(((r + 1) % 8) << 5), 1'b1, noWrite);
        end
        issue(16'hD705, 1'b1, noWrite);  // SWSP reads SP
        issue(16'h607F, 1'b1, noWrite);  // BTEQZ reads T
        issue(16'hF300, 1'b1, noWrite);  // MFIH reads IH

        ////////////////////////////////////////////////////////////
        // Every opcode class, sub-function and unknown encoding

        dirList = '{16'h0800, 16'h1234, 16'h1400, 16'h2180, 16'h2000, 16'h2A05,
                    16'h3140, 16'h3394, 16'h322F, 16'h3003, 16'h3001, 16'h3002,
                    16'h414F, 16'h4107, 16'h4B80, 16'h5AFF, 16'h6380, 16'h607F,
                    16'h64A0, 16'h6100, 16'h6700, 16'h6CAB, 16'h79C0, 16'h92F0,
                    16'h9970, 16'hD705, 16'hD8BF, 16'hE14D, 16'hE4BB, 16'hE000,
                    16'hE002, 16'hEB00, 16'hEA40, 16'hE942, 16'hE94A, 16'hE96B,
                    16'hE94C, 16'hE94D, 16'hE94F, 16'hE820, 16'hE801, 16'hE81F,
                    16'hF300, 16'hF201, 16'hF202, 16'hF380, 16'h0000, 16'h1800,
                    16'h3800, 16'h5000, 16'h7000, 16'h8000, 16'hA000, 16'hF800};
        foreach (dirList[k]) begin
            issue(dirList[k], 1'b1, noWrite);
        end

        // Write, then read back one cycle later
        issue(16'h0800, 1'b0, packWriteBack(4'd3, 16'hBEEF));
        issue(16'h7860, 1'b1, noWrite);  // MOVE r0, r3
        issue(16'h0800, 1'b0, packWriteBack(regSp, 16'h7FF0));
        issue(16'hD705, 1'b1, noWrite);
        issue(16'h0800, 1'b0, packWriteBack(regT, 16'h0001));
        issue(16'h607F, 1'b1, noWrite);
        issue(16'h0800, 1'b0, packWriteBack(regIh, 16'h00A5));
        issue(16'hF300, 1'b1, noWrite);
        issue(16'h0800, 1'b0, packWriteBack(regNone, 16'h1234));
        issue(16'h0000, 1'b1, noWrite);  // Zero register stays 0

        // Same-cycle forwarding on both ports
        issue(16'hDDA0, 1'b1, packWriteBack(4'd5, 16'hC0DE));
        issue(16'hE14D, 1'b1, packWriteBack(4'd2, 16'h5A5A));

        ////////////////////////////////////////////////////////////
        // Random stream with gaps

        for (int n = 0; n < 400; n++) begin
            rnd = $random(seed);
            gap = $random(seed);
            wbRand.regIdx = rnd[3:0];
            rnd = $random(seed);
            wbRand.data = rnd[15:0];
            rnd = $random(seed);
            issue(rnd[15:0], gap[1:0] != 2'b00, wbRand);
        end
        issue(16'h0800, 1'b0, noWrite);

        waited = 0;
        while (checkCount < issuedCount && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (checkCount < issuedCount) begin
            $display("Timed out waiting for the checker to see every valid output");
            timeouts++;
        end
        @(posedge clk);

        $display("Checked %0d of %0d outputs, %0d value errors, %0d timeouts",
                 checkCount, issuedCount, errorCount, timeouts);
        if (errorCount == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
